// File: include/spm_params.svh
/*
 * scratchpad sizing macros
 * bank count, rows per bank, word and tag widths shared by packages and rtl
 */
`ifndef SPM_PARAMS_SVH
`define SPM_PARAMS_SVH

// number of interleaved banks, power of two
`define SPM_BANKS 4

// words held by each bank, power of two
`define SPM_ROWS 256

// word width in bits, must stay a multiple of 8 for byte masking
`define SPM_DATA_W 32

// requester tag carried back with every read
`define SPM_TAG_W 4

`endif

// File: verilog/spm_map_pkg.sv
/*
 * scratchpad address map
 * word address split into a low bank index and an upper row index
 */
`include "spm_params.svh"

package spm_map_pkg;

  localparam int unsigned BANK_W = $clog2(`SPM_BANKS); // low address bits
  localparam int unsigned ROW_W  = $clog2(`SPM_ROWS);  // upper address bits
  localparam int unsigned ADDR_W = ROW_W + BANK_W;     // full word address

  typedef logic [ADDR_W-1:0] addr_t;     // word address, not byte address
  typedef logic [BANK_W-1:0] bank_idx_t; // which bank answers
  typedef logic [ROW_W-1:0]  row_t;      // word inside a bank

  // row over bank, same width as addr_t
  // a cast of addr_t gives the split for free, no logic
  typedef struct packed {
    row_t      row;  // msbs
    bank_idx_t bank; // lsbs, consecutive words hit consecutive banks
  } addr_split_t;

endpackage

// File: verilog/spm_req_pkg.sv
/*
 * scratchpad transaction types
 * requester strobe, per-bank request, gather steering and read response
 */
`include "spm_params.svh"

package spm_req_pkg;
  import spm_map_pkg::*;

  localparam int unsigned BE_W = `SPM_DATA_W / 8; // one enable per byte

  typedef logic [`SPM_DATA_W-1:0] word_t;
  typedef logic [BE_W-1:0]        be_t;  // bit k enables byte k from the lsb
  typedef logic [`SPM_TAG_W-1:0]  tag_t;

  // top-level request, valid is a single-cycle strobe
  typedef struct packed {
    logic  valid;
    logic  we;    // 1 write, 0 read
    addr_t addr;
    word_t wdata;
    be_t   be;    // only looked at on writes
    tag_t  tag;   // returned on reads
  } spm_req_t;

  // what one bank sees, bank bits already stripped off
  typedef struct packed {
    logic  valid;
    logic  we;
    row_t  row;
    word_t wdata;
    be_t   be;
    tag_t  tag;
  } bank_req_t;

  // dispatch to gather, one cycle behind the request
  typedef struct packed {
    logic      rd;   // a read was issued last cycle
    bank_idx_t bank; // and this bank holds its data
  } bank_sel_t;

  typedef struct packed {
    logic  valid;
    word_t rdata;
    tag_t  tag;
  } spm_resp_t;

endpackage

// File: verilog/spm_bank.sv
/*
 * scratchpad bank
 * synchronous single-port ram, one read or one write per cycle
 * byte-masked writes, registered read word and tag
 */
`timescale 1ns/1ps
`include "spm_params.svh"

module spm_bank
  import spm_req_pkg::*;
(
  input  logic      clk_i,
  input  logic      rst_n_i,
  input  bank_req_t bank_req_i, // from dispatch, valid only when this bank is hit
  output word_t     rdata_o,    // valid the cycle after a read
  output tag_t      tag_o       // tag of that read
);

  // storage, behavioral only
  word_t mem [`SPM_ROWS];

  word_t rdata_q; // read port output latch
  tag_t  tag_q;

  logic  rd_en;
  logic  wr_en;

  // single port, so we picks the direction
  assign rd_en = bank_req_i.valid & ~bank_req_i.we;
  assign wr_en = bank_req_i.valid &  bank_req_i.we;

  // byte-masked write
  // disabled bytes keep their old contents
  always_ff @(posedge clk_i)
  begin
    if (wr_en)
    begin
      for (int b = 0; b < BE_W; b++)
      begin
        if (bank_req_i.be[b])
          mem[bank_req_i.row][b*8 +: 8] <= bank_req_i.wdata[b*8 +: 8]; // lane b
      end
    end
  end

  // synchronous read
  // the output only moves on a read and holds otherwise, like a macro q pin
  always_ff @(posedge clk_i)
  begin
    if (rd_en)
      rdata_q <= mem[bank_req_i.row];
  end

  // tag follows the read word through the same cycle
  always_ff @(posedge clk_i)
  begin
    if (!rst_n_i)
      tag_q <= '0;
    else if (rd_en)
      tag_q <= bank_req_i.tag; // hold between reads
  end

  assign rdata_o = rdata_q;
  assign tag_o   = tag_q;

endmodule

// File: verilog/spm_dispatch.sv
/*
 * scratchpad request dispatch
 * decodes the low address bits to a one-hot bank request, same cycle
 * and registers the bank index and read strobe for the gather stage
 */
`timescale 1ns/1ps
`include "spm_params.svh"

module spm_dispatch
  import spm_map_pkg::*;
  import spm_req_pkg::*;
(
  input  logic                        clk_i,
  input  logic                        rst_n_i,
  input  spm_req_t                    req_i,      // one strobe per cycle, no handshake
  output bank_req_t [`SPM_BANKS-1:0]  bank_req_o, // one-hot on valid
  output bank_sel_t                   sel_o       // steering for gather, 1 cycle late
);

  addr_split_t split; // row and bank view of req_i.addr
  logic        rd_req;

  logic        rd_q;   // read issued last cycle
  bank_idx_t   bank_q; // bank it went to

  // pure reinterpretation, widths are equal by construction
  assign split  = addr_split_t'(req_i.addr);
  assign rd_req = req_i.valid & ~req_i.we;

  // payload broadcast to every slot
  // only the addressed slot gets valid, others stay idle
  always_comb
  begin
    for (int b = 0; b < `SPM_BANKS; b++)
    begin
      bank_req_o[b].valid = req_i.valid && (split.bank == bank_idx_t'(b));
      bank_req_o[b].we    = bank_req_o[b].valid & req_i.we; // idle slots never write
      bank_req_o[b].row   = split.row;
      bank_req_o[b].wdata = req_i.wdata;
      bank_req_o[b].be    = req_i.be;
      bank_req_o[b].tag   = req_i.tag;
    end
  end

  // read strobe, lines up with the bank output in cycle t+1
  always_ff @(posedge clk_i)
  begin
    if (!rst_n_i)
      rd_q <= 1'b0;
    else
      rd_q <= rd_req; // writes leave it low
  end

  // bank index only matters when rd_q is set
  always_ff @(posedge clk_i)
  begin
    if (rd_req)
      bank_q <= split.bank;
  end

  assign sel_o.rd   = rd_q;
  assign sel_o.bank = bank_q;

endmodule

// File: verilog/spm_gather.sv
/*
 * scratchpad response gather
 * picks the answering bank by the registered index
 * and registers word, tag and valid into the response
 */
`timescale 1ns/1ps
`include "spm_params.svh"

module spm_gather
  import spm_req_pkg::*;
(
  input  logic                    clk_i,
  input  logic                    rst_n_i,
  input  bank_sel_t               sel_i,        // read strobe and bank, cycle t+1
  input  word_t [`SPM_BANKS-1:0]  bank_rdata_i, // every bank's read word
  input  tag_t  [`SPM_BANKS-1:0]  bank_tag_i,   // every bank's read tag
  output spm_resp_t               resp_o        // valid in cycle t+2
);

  word_t rdata_mux;
  tag_t  tag_mux;

  logic  valid_q;
  word_t rdata_q;
  tag_t  tag_q;

  // bank mux, index comes straight from the dispatch register
  assign rdata_mux = bank_rdata_i[sel_i.bank];
  assign tag_mux   = bank_tag_i[sel_i.bank];

  // response strobe, exactly one cycle per read
  always_ff @(posedge clk_i)
  begin
    if (!rst_n_i)
      valid_q <= 1'b0;
    else
      valid_q <= sel_i.rd;
  end

  // payload loads on a read and holds after
  always_ff @(posedge clk_i)
  begin
    if (sel_i.rd)
    begin
      rdata_q <= rdata_mux;
      tag_q   <= tag_mux;
    end
  end

  assign resp_o.valid = valid_q;
  assign resp_o.rdata = rdata_q;
  assign resp_o.tag   = tag_q;

endmodule

// File: verilog/spm_top.sv
/*
 * banked scratchpad memory
 * dispatch, interleaved single-port banks and response gather
 * fixed 2-cycle read latency, writes return nothing
 */
`timescale 1ns/1ps
`include "spm_params.svh"

module spm_top
  import spm_req_pkg::*;
(
  input  logic      clk_i,
  input  logic      rst_n_i,
  input  spm_req_t  req_i,  // requester strobe
  output spm_resp_t resp_o  // read response, no back-pressure
);

  bank_req_t [`SPM_BANKS-1:0] bank_req;   // dispatch to banks
  word_t     [`SPM_BANKS-1:0] bank_rdata; // banks to gather
  tag_t      [`SPM_BANKS-1:0] bank_tag;
  bank_sel_t                  sel;        // dispatch to gather

  // decode, 0 cycles to the banks
  spm_dispatch u_dispatch (
    .clk_i      (clk_i),
    .rst_n_i    (rst_n_i),
    .req_i      (req_i),
    .bank_req_o (bank_req),
    .sel_o      (sel)
  );

  // one bank per low address value
  for (genvar g = 0; g < `SPM_BANKS; g++)
  begin : g_bank
    spm_bank u_bank (
      .clk_i      (clk_i),
      .rst_n_i    (rst_n_i),
      .bank_req_i (bank_req[g]),
      .rdata_o    (bank_rdata[g]),
      .tag_o      (bank_tag[g])
    );
  end

  // mux and register, last cycle of latency
  spm_gather u_gather (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .sel_i        (sel),
    .bank_rdata_i (bank_rdata),
    .bank_tag_i   (bank_tag),
    .resp_o       (resp_o)
  );

endmodule

// File: bench/spm_checker.sv
/*
 * scratchpad protocol checker
 * response latency, reset state and one-hot bank selection
 */
`timescale 1ns/1ps
`include "spm_params.svh"

module spm_checker
  import spm_req_pkg::*;
(
  input  logic                        clk_i,
  input  logic                        rst_n_i,
  input  spm_req_t                    req_i,
  input  bank_req_t [`SPM_BANKS-1:0]  bank_req_i, // dispatch outputs
  input  spm_resp_t                   resp_i      // top-level response
);

  logic [`SPM_BANKS-1:0] bank_vld; // valid bit of every bank slot
  logic                  rd_req;

  int unsigned rst_fails = 0;
  int unsigned lat_fails = 0;
  int unsigned sel_fails = 0;
  int unsigned fail_total; // read by the testbench

  always_comb
  begin
    for (int b = 0; b < `SPM_BANKS; b++)
      bank_vld[b] = bank_req_i[b].valid;
  end

  assign rd_req     = req_i.valid & ~req_i.we;
  assign fail_total = rst_fails + lat_fails + sel_fails;

  // sync reset clears the strobe on the next edge
  assert property (@(posedge clk_i) !rst_n_i |=> !resp_i.valid)
  else
  begin
    rst_fails++;
    $error("resp valid high while reset is held");
  end

  // exactly 2 cycles after a read, never after a write
  assert property (@(posedge clk_i) disable iff (!rst_n_i)
    resp_i.valid == $past(rd_req, 2))
  else
  begin
    lat_fails++;
    $error("resp valid does not follow a read by 2 cycles");
  end

  // one bank per valid request, none when idle
  assert property (@(posedge clk_i) disable iff (!rst_n_i)
    $onehot0(bank_vld) && (req_i.valid == |bank_vld))
  else
  begin
    sel_fails++;
    $error("bank request select is not one-hot");
  end

endmodule

bind spm_top spm_checker u_checker (
  .clk_i      (clk_i),
  .rst_n_i    (rst_n_i),
  .req_i      (req_i),
  .bank_req_i (bank_req),
  .resp_i     (resp_o)
);

// File: bench/spm_tb.sv
/*
 * banked scratchpad testbench
 * directed tests against a byte-masked reference memory
 * reads matched in order and each due 2 cycles after issue
 */
`timescale 1ns/1ps
`include "spm_params.svh"

module spm_tb
  import spm_map_pkg::*;
  import spm_req_pkg::*;
();

  localparam int unsigned WAIT_MAX = 20; // cycles allowed to drain reads

  logic      clk;
  logic      rst_n;
  spm_req_t  req;
  spm_resp_t resp;

  word_t       ref_mem [addr_t]; // only addresses that were written
  word_t       exp_data_q [$];
  tag_t        exp_tag_q [$];
  int unsigned exp_due_q [$];    // falling edge on which the response shows
  int unsigned n_neg;            // falling edges since reset release

  spm_top uut (
    .clk_i   (clk),
    .rst_n_i (rst_n),
    .req_i   (req),
    .resp_o  (resp)
  );

  initial
  begin
    clk = 1'b0;
    forever #20 clk = ~clk; // 40 ns period
  end

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("TEST RESULT: FAIL");
    $fatal(1, "simulation stopped at first error");
  endtask

  task automatic word_check(input string name, input word_t got, input word_t exp);
    if (got !== exp)
      abort_run($sformatf("Error: %s got 0x%h, expected 0x%h", name, got, exp));
  endtask

  task automatic tag_check(input string name, input tag_t got, input tag_t exp);
    if (got !== exp)
      abort_run($sformatf("Error: %s got 0x%h, expected 0x%h", name, got, exp));
  endtask

  task automatic valid_check(input string name, input logic got, input logic exp);
    if (got !== exp)
      abort_run($sformatf("Error: %s got 0x%h, expected 0x%h", name, got, exp));
  endtask

  // enabled bytes from the new word and the rest kept as before
  function automatic word_t merge_bytes(input word_t old_w, input word_t new_w, input be_t be);
    word_t res;
    res = old_w;
    for (int k = 0; k < BE_W; k++)
    begin
      if (be[k])
        res[k*8 +: 8] = new_w[k*8 +: 8];
    end
    return res;
  endfunction

  // response sampled on the falling edge where it is stable
  task automatic watch_resp();
    if (exp_due_q.size() != 0 && exp_due_q[0] == n_neg)
    begin
      valid_check("resp_o.valid", resp.valid, 1'b1);
      word_check("resp_o.rdata", resp.rdata, exp_data_q[0]);
      tag_check("resp_o.tag", resp.tag, exp_tag_q[0]);
      void'(exp_data_q.pop_front());
      void'(exp_tag_q.pop_front());
      void'(exp_due_q.pop_front());
    end
    else
      valid_check("resp_o.valid", resp.valid, 1'b0); // nothing due this cycle
  endtask

  task automatic next_cycle();
    @(negedge clk);
    n_neg++;
    req.valid = 1'b0; // idle unless driven again right away
    if (uut.u_checker.fail_total != 0)
      abort_run("an assertion in the checker failed");
    watch_resp();
  endtask

  task automatic write_word(input addr_t addr, input word_t data, input be_t be);
    word_t old_w;
    old_w = ref_mem.exists(addr) ? ref_mem[addr] : '0; // tests never merge into unwritten words
    ref_mem[addr] = merge_bytes(old_w, data, be);
    req.valid = 1'b1;
    req.we    = 1'b1;
    req.addr  = addr;
    req.wdata = data;
    req.be    = be;
    req.tag   = '0;
    next_cycle();
  endtask

  task automatic read_word(input addr_t addr, input tag_t tag);
    if (!ref_mem.exists(addr))
      abort_run("test tried to read an address it never wrote");
    exp_data_q.push_back(ref_mem[addr]);
    exp_tag_q.push_back(tag);
    exp_due_q.push_back(n_neg + 2); // fixed 2-cycle latency
    req.valid = 1'b1;
    req.we    = 1'b0;
    req.addr  = addr;
    req.wdata = '0;
    req.be    = '0;
    req.tag   = tag;
    next_cycle();
  endtask

  task automatic drain_reads();
    int unsigned waited;
    waited = 0;
    while (exp_due_q.size() != 0)
    begin
      if (waited >= WAIT_MAX)
        abort_run("timeout waiting for outstanding read responses");
      next_cycle();
      waited++;
    end
  endtask

  // no requests and so no responses
  task automatic reset_quiet();
    for (int i = 0; i < 8; i++)
      next_cycle(); // valid must stay low with nothing due
  endtask

  task automatic write_then_read();
    write_word(addr_t'(9), word_t'(32'hcafe_f00d), '1);
    read_word(addr_t'(9), tag_t'(5));
    drain_reads();
  endtask

  // second write only touches the masked lanes
  task automatic byte_merge();
    write_word(addr_t'(22), word_t'(32'h1122_3344), '1);
    write_word(addr_t'(22), word_t'(32'haabb_ccdd), be_t'(4'b0101));
    write_word(addr_t'(23), word_t'(32'h5566_7788), '1);
    write_word(addr_t'(23), word_t'(32'h99ee_ff00), be_t'(4'b1000));
    read_word(addr_t'(22), tag_t'(1));
    read_word(addr_t'(23), tag_t'(2));
    drain_reads();
  endtask

  // consecutive words land in consecutive banks
  task automatic bank_sweep();
    for (int i = 0; i < 2 * `SPM_BANKS; i++)
      write_word(addr_t'(64 + i), word_t'($urandom), '1);
    for (int i = 0; i < 2 * `SPM_BANKS; i++)
      read_word(addr_t'(64 + i), tag_t'(i)); // back to back with several in flight
    drain_reads();
  endtask

  task automatic random_mix();
    addr_t addr;
    logic  do_write;
    be_t   be;
    for (int n = 0; n < 200; n++)
    begin
      addr     = addr_t'($urandom_range(31, 0)); // rows 0..7 in every bank
      do_write = ($urandom_range(1, 0) == 1) || !ref_mem.exists(addr);
      be       = ref_mem.exists(addr) ? be_t'($urandom) : '1; // first write is full
      if (do_write)
        write_word(addr, word_t'($urandom), be);
      else
        read_word(addr, tag_t'($urandom));
    end
    drain_reads();
  endtask

  initial
  begin
    void'($urandom(17));
    rst_n = 1'b0;
    req   = '0;
    n_neg = 0;
    repeat (5) @(negedge clk); // 5 rising edges in reset
    rst_n = 1'b1;

    reset_quiet();
    write_then_read();
    byte_merge();
    bank_sweep();
    random_mix();

    $display("TEST RESULT: PASS");
    $finish;
  end

endmodule

// File: tb.f
+incdir+include
verilog/spm_map_pkg.sv
verilog/spm_req_pkg.sv
verilog/spm_bank.sv
verilog/spm_dispatch.sv
verilog/spm_gather.sv
verilog/spm_top.sv
bench/spm_checker.sv
bench/spm_tb.sv

// File: Makefile
# Verilator build for the banked scratchpad testbench
# every variable below can be overridden on the make command line

VERILATOR ?= verilator
TOP       ?= spm_tb
FILELIST  ?= tb.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0 --timescale 1ns/1ps
ERR_LIMIT ?= 100
PASS_MSG  ?= TEST RESULT: PASS

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)

# the error limit keeps assertion failures visible to the testbench
run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP) +verilator+error+limit+$(ERR_LIMIT))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
